// ==== source/harness_pkg.sv ====
`default_nettype none

package harness_pkg;

  // Bus widths shared by the AXI4-Lite side and the memory side
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // SRAM depth in words
  localparam int unsigned NUM_WORDS = 1024;

  // Memory map
  // One address bit splits SRAM from host control
  localparam logic [ADDR_W-1:0] HOST_BASE    = 32'h1000_0000;
  localparam int unsigned       HOST_SEL_BIT = 28;

  // Host control register offsets
  localparam logic [ADDR_W-1:0] HOST_CHAR_OFS = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] HOST_EXIT_OFS = 32'h0000_0004;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage : harness_pkg

`default_nettype wire

// ==== source/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-request memory port
// A request is one cycle of req high and rdata follows one cycle later
interface mem_req_if #(
  parameter int unsigned AddrWidth = harness_pkg::ADDR_W,
  parameter int unsigned DataWidth = harness_pkg::DATA_W
);

  logic                   req;
  logic                   we;
  logic [AddrWidth-1:0]   addr;
  logic [DataWidth/8-1:0] be;
  logic [DataWidth-1:0]   wdata;
  logic [DataWidth-1:0]   rdata;

  modport mgr (output req, output we, output addr, output be, output wdata, input rdata);

  modport dev (input req, input we, input addr, input be, input wdata, output rdata);

endinterface : mem_req_if

`default_nettype wire

// ==== source/axil_to_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_to_mem #(
  parameter int unsigned AddrWidth = harness_pkg::ADDR_W,
  parameter int unsigned DataWidth = harness_pkg::DATA_W
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // Write address and data
  input  wire logic [AddrWidth-1:0]   awaddr_i,
  input  wire logic                   awvalid_i,
  output      logic                   awready_o,
  input  wire logic [DataWidth-1:0]   wdata_i,
  input  wire logic [DataWidth/8-1:0] wstrb_i,
  input  wire logic                   wvalid_i,
  output      logic                   wready_o,
  // Write response
  output      logic [1:0]             bresp_o,
  output      logic                   bvalid_o,
  input  wire logic                   bready_i,
  // Read address and data
  input  wire logic [AddrWidth-1:0]   araddr_i,
  input  wire logic                   arvalid_i,
  output      logic                   arready_o,
  output      logic [DataWidth-1:0]   rdata_o,
  output      logic [1:0]             rresp_o,
  output      logic                   rvalid_o,
  input  wire logic                   rready_i,
  // Memory side
  mem_req_if.mgr                      mem
);

  import harness_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, WAIT, RESP} state_e;

  state_e                 state_q;
  logic                   aw_seen_q;
  logic                   w_seen_q;
  logic                   we_q;
  logic [AddrWidth-1:0]   addr_q;
  logic [DataWidth-1:0]   wdata_q;
  logic [DataWidth/8-1:0] be_q;
  logic [DataWidth-1:0]   rdata_q;

  logic idle;
  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic wr_go;
  logic resp_valid;
  logic resp_done;

  assign idle = (state_q == IDLE);

  // AW and W may arrive apart, a write starts once both are in
  // Reads wait while any part of a write is pending
  assign awready_o = idle && !aw_seen_q;
  assign wready_o  = idle && !w_seen_q;
  assign arready_o = idle && !aw_seen_q && !w_seen_q && !awvalid_i && !wvalid_i;

  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign ar_hs = arvalid_i && arready_o;
  assign wr_go = (aw_seen_q || aw_hs) && (w_seen_q || w_hs);

  // Response is offered from the cycle the memory answers
  assign resp_valid = (state_q == WAIT) || (state_q == RESP);
  assign resp_done  = we_q ? bready_i : rready_i;

  assign bvalid_o = resp_valid && we_q;
  assign rvalid_o = resp_valid && !we_q;
  assign bresp_o  = RESP_OKAY;
  assign rresp_o  = RESP_OKAY;
  assign rdata_o  = (state_q == RESP) ? rdata_q : mem.rdata;

  assign mem.req   = (state_q == REQ);
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.be    = be_q;
  assign mem.wdata = wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      aw_seen_q <= 1'b0;
      w_seen_q  <= 1'b0;
      we_q      <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_go) begin
            we_q      <= 1'b1;
            aw_seen_q <= 1'b0;
            w_seen_q  <= 1'b0;
            state_q   <= REQ;
          end else if (ar_hs) begin
            we_q    <= 1'b0;
            state_q <= REQ;
          end else begin
            aw_seen_q <= aw_seen_q || aw_hs;
            w_seen_q  <= w_seen_q || w_hs;
          end
        end
        REQ:  state_q <= WAIT;
        WAIT: state_q <= resp_done ? IDLE : RESP;
        RESP: begin
          if (resp_done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      addr_q <= awaddr_i;
    end else if (ar_hs) begin
      addr_q <= araddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      be_q    <= wstrb_i;
    end
    // Hold read data for a stalled R channel
    if (state_q == WAIT) begin
      rdata_q <= mem.rdata;
    end
  end

endmodule : axil_to_mem

`default_nettype wire

// ==== source/mem_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_router (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  mem_req_if.dev    up,
  mem_req_if.mgr    sram,
  mem_req_if.mgr    host
);

  import harness_pkg::*;

  logic host_sel;
  logic host_sel_q;

  assign host_sel = (up.addr[HOST_SEL_BIT] == HOST_BASE[HOST_SEL_BIT]);

  // Only the selected target sees the request
  assign sram.req   = up.req && !host_sel;
  assign sram.we    = up.we;
  assign sram.addr  = up.addr;
  assign sram.be    = up.be;
  assign sram.wdata = up.wdata;

  assign host.req   = up.req && host_sel;
  assign host.we    = up.we;
  assign host.addr  = up.addr;
  assign host.be    = up.be;
  assign host.wdata = up.wdata;

  // Selection remembered for the data cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      host_sel_q <= 1'b0;
    end else if (up.req) begin
      host_sel_q <= host_sel;
    end
  end

  assign up.rdata = host_sel_q ? host.rdata : sram.rdata;

endmodule : mem_router

`default_nettype wire

// ==== source/tc_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tc_sram #(
  parameter int unsigned NumWords  = harness_pkg::NUM_WORDS,
  parameter int unsigned DataWidth = harness_pkg::DATA_W
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  mem_req_if.dev    mem
);

  localparam int unsigned NumBytes = DataWidth / 8;
  localparam int unsigned ByteBits = $clog2(NumBytes);
  localparam int unsigned IdxBits  = $clog2(NumWords);

  logic [DataWidth-1:0] ram [NumWords];
  logic [IdxBits-1:0]   idx;
  logic [DataWidth-1:0] rdata_q;

  // Word index above the byte offset, upper bits dropped so the array wraps
  assign idx = mem.addr[ByteBits +: IdxBits];

  always_ff @(posedge clk_i) begin
    if (mem.req && mem.we) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (mem.be[b]) begin
          ram[idx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (mem.req && !mem.we) begin
      rdata_q <= ram[idx];
    end
  end

  assign mem.rdata = rdata_q;

endmodule : tc_sram

`default_nettype wire

// ==== source/host_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_ctrl #(
  parameter int unsigned DataWidth = harness_pkg::DATA_W
) (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  mem_req_if.dev              mem,
  output logic [DataWidth-1:0] exit_code_o,
  output logic                 exit_valid_o,
  output logic [7:0]           char_o,
  output logic                 char_valid_o,
  output logic [15:0]          char_count_o
);

  import harness_pkg::*;

  // Register select uses the low address bits only
  localparam int unsigned OfsBits = 4;

  logic                 hit_char;
  logic                 hit_exit;
  logic [DataWidth-1:0] rdata_q;

  assign hit_char = (mem.addr[OfsBits-1:0] == HOST_CHAR_OFS[OfsBits-1:0]);
  assign hit_exit = (mem.addr[OfsBits-1:0] == HOST_EXIT_OFS[OfsBits-1:0]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_code_o  <= '0;
      exit_valid_o <= 1'b0;
      char_o       <= '0;
      char_valid_o <= 1'b0;
      char_count_o <= '0;
      rdata_q      <= '0;
    end else begin
      char_valid_o <= 1'b0;
      if (mem.req && mem.we) begin
        // Character needs the low byte lane
        if (hit_char && mem.be[0]) begin
          char_o       <= mem.wdata[7:0];
          char_valid_o <= 1'b1;
          char_count_o <= char_count_o + 16'd1;
        end
        if (hit_exit) begin
          for (int b = 0; b < DataWidth/8; b++) begin
            if (mem.be[b]) begin
              exit_code_o[b*8 +: 8] <= mem.wdata[b*8 +: 8];
            end
          end
          // Sticky until reset
          exit_valid_o <= 1'b1;
        end
      end else if (mem.req) begin
        if (hit_char) begin
          rdata_q <= {{(DataWidth-16){1'b0}}, char_count_o};
        end else if (hit_exit) begin
          rdata_q <= exit_code_o;
        end else begin
          rdata_q <= '0;
        end
      end
    end
  end

  assign mem.rdata = rdata_q;

endmodule : host_ctrl

`default_nettype wire

// ==== source/harness_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module harness_top #(
  parameter int unsigned AddrWidth = harness_pkg::ADDR_W,
  parameter int unsigned DataWidth = harness_pkg::DATA_W,
  parameter int unsigned NumWords  = harness_pkg::NUM_WORDS
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // AXI4-Lite subordinate
  input  wire logic [AddrWidth-1:0]   awaddr_i,
  input  wire logic                   awvalid_i,
  output      logic                   awready_o,
  input  wire logic [DataWidth-1:0]   wdata_i,
  input  wire logic [DataWidth/8-1:0] wstrb_i,
  input  wire logic                   wvalid_i,
  output      logic                   wready_o,
  output      logic [1:0]             bresp_o,
  output      logic                   bvalid_o,
  input  wire logic                   bready_i,
  input  wire logic [AddrWidth-1:0]   araddr_i,
  input  wire logic                   arvalid_i,
  output      logic                   arready_o,
  output      logic [DataWidth-1:0]   rdata_o,
  output      logic [1:0]             rresp_o,
  output      logic                   rvalid_o,
  input  wire logic                   rready_i,
  // Host side
  output      logic [DataWidth-1:0]   exit_code_o,
  output      logic                   exit_valid_o,
  output      logic [7:0]             char_o,
  output      logic                   char_valid_o,
  output      logic [15:0]            char_count_o
);

  mem_req_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) bridge_mem ();
  mem_req_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) sram_mem ();
  mem_req_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) host_mem ();

  axil_to_mem #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth)
  ) i_axil_to_mem (
    .clk_i    (clk_i     ),
    .rst_n_i  (rst_n_i   ),
    .awaddr_i (awaddr_i  ),
    .awvalid_i(awvalid_i ),
    .awready_o(awready_o ),
    .wdata_i  (wdata_i   ),
    .wstrb_i  (wstrb_i   ),
    .wvalid_i (wvalid_i  ),
    .wready_o (wready_o  ),
    .bresp_o  (bresp_o   ),
    .bvalid_o (bvalid_o  ),
    .bready_i (bready_i  ),
    .araddr_i (araddr_i  ),
    .arvalid_i(arvalid_i ),
    .arready_o(arready_o ),
    .rdata_o  (rdata_o   ),
    .rresp_o  (rresp_o   ),
    .rvalid_o (rvalid_o  ),
    .rready_i (rready_i  ),
    .mem      (bridge_mem)
  );

  mem_router i_mem_router (
    .clk_i  (clk_i     ),
    .rst_n_i(rst_n_i   ),
    .up     (bridge_mem),
    .sram   (sram_mem  ),
    .host   (host_mem  )
  );

  tc_sram #(
    .NumWords (NumWords ),
    .DataWidth(DataWidth)
  ) i_sram (
    .clk_i  (clk_i   ),
    .rst_n_i(rst_n_i ),
    .mem    (sram_mem)
  );

  host_ctrl #(
    .DataWidth(DataWidth)
  ) i_host_ctrl (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .mem         (host_mem    ),
    .exit_code_o (exit_code_o ),
    .exit_valid_o(exit_valid_o),
    .char_o      (char_o      ),
    .char_valid_o(char_valid_o),
    .char_count_o(char_count_o)
  );

endmodule : harness_top

`default_nettype wire

// ==== include/tb_axil_tasks.svh ====
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_state[31]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// Response held back by the manager must stay put and block new requests
task automatic check_stalled(input logic valid, input logic [31:0] held,
                             input logic [31:0] now);
  if (valid !== 1'b1) begin
    $display("test %s: response dropped before it transferred", cur_test);
    test_errs++;
  end
  check_eq("held response", held, now);
  if (awready || wready || arready) begin
    $display("test %s: new request accepted while a response was stalled", cur_test);
    test_errs++;
  end
endtask

// AW and W offered together while B is held low for hold cycles
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int hold, output logic [1:0] resp);
  int         waited;
  bit         done;
  logic [1:0] held;
  resp    = 'x;
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wstrb   = strb;
  wvalid  = 1'b1;
  bready  = (hold == 0);
  done    = 1'b0;
  for (waited = 0; waited < HS_LIMIT && !done; waited++) begin
    @(negedge clk);
    done = awready && wready;
  end
  @(posedge clk);
  #1;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  if (!done) begin
    $display("test %s: write address and data were never accepted", cur_test);
    test_errs++;
    bready = 1'b1;
    return;
  end
  done = 1'b0;
  for (waited = 0; waited < HS_LIMIT && !done; waited++) begin
    @(negedge clk);
    done = bvalid;
  end
  if (!done) begin
    $display("test %s: write response never arrived", cur_test);
    test_errs++;
    @(posedge clk);
    #1;
    bready = 1'b1;
    return;
  end
  held = bresp;
  repeat (hold) begin
    @(negedge clk);
    check_stalled(bvalid, 32'(held), 32'(bresp));
  end
  if (hold > 0) begin
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(negedge clk);
    check_stalled(bvalid, 32'(held), 32'(bresp));
  end
  resp = bresp;
  @(posedge clk);
  #1;
endtask

// AR then R with R held low for hold cycles
task automatic axil_read(input logic [31:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
  int          waited;
  bit          done;
  logic [31:0] held;
  data    = 'x;
  resp    = 'x;
  araddr  = addr;
  arvalid = 1'b1;
  rready  = (hold == 0);
  done    = 1'b0;
  for (waited = 0; waited < HS_LIMIT && !done; waited++) begin
    @(negedge clk);
    done = arready;
  end
  @(posedge clk);
  #1;
  arvalid = 1'b0;
  if (!done) begin
    $display("test %s: read address was never accepted", cur_test);
    test_errs++;
    rready = 1'b1;
    return;
  end
  done = 1'b0;
  for (waited = 0; waited < HS_LIMIT && !done; waited++) begin
    @(negedge clk);
    done = rvalid;
  end
  if (!done) begin
    $display("test %s: read response never arrived", cur_test);
    test_errs++;
    @(posedge clk);
    #1;
    rready = 1'b1;
    return;
  end
  held = rdata;
  repeat (hold) begin
    @(negedge clk);
    check_stalled(rvalid, held, rdata);
  end
  if (hold > 0) begin
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(negedge clk);
    check_stalled(rvalid, held, rdata);
  end
  data = rdata;
  resp = rresp;
  @(posedge clk);
  #1;
endtask

`endif

// ==== dv/tb_harness.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_harness;

  import harness_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 8;
  localparam int NUM_TESTS  = 17;
  localparam int HS_LIMIT   = 16;
  localparam int IDX_W      = $clog2(NUM_WORDS);
  // 20 cycles per table entry plus one slot for the reset check
  localparam int WATCHDOG_NS = ((NUM_TESTS + 1) * 20 + RST_CYCLES) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [31:0] exit_code;
  logic        exit_valid;
  logic [7:0]  char_data;
  logic        char_valid;
  logic [15:0] char_count;

  // Stimulus table, expected host state after each entry
  string       tbl_name   [NUM_TESTS];
  bit          tbl_wr     [NUM_TESTS];
  logic [31:0] tbl_addr   [NUM_TESTS];
  logic [31:0] tbl_data   [NUM_TESTS];
  logic [3:0]  tbl_strb   [NUM_TESTS];
  int          tbl_hold   [NUM_TESTS];
  logic [31:0] tbl_exp    [NUM_TESTS];
  logic [15:0] tbl_count  [NUM_TESTS];
  logic        tbl_xvalid [NUM_TESTS];
  logic [31:0] tbl_xcode  [NUM_TESTS];
  int          n_entries;

  // Reference model
  logic [31:0] ref_mem [NUM_WORDS];
  logic [15:0] m_count;
  logic [31:0] m_exit;
  logic        m_exit_valid;

  logic [31:0] lfsr_state;
  string       cur_test;
  int          test_errs   = 0;
  int          n_pass      = 0;
  int          n_fail      = 0;
  int          char_pulses = 0;

  harness_top #(
    .AddrWidth(ADDR_W),
    .DataWidth(DATA_W),
    .NumWords (NUM_WORDS)
  ) dut_i (
    .clk_i       (clk       ),
    .rst_n_i     (rst_n     ),
    .awaddr_i    (awaddr    ),
    .awvalid_i   (awvalid   ),
    .awready_o   (awready   ),
    .wdata_i     (wdata     ),
    .wstrb_i     (wstrb     ),
    .wvalid_i    (wvalid    ),
    .wready_o    (wready    ),
    .bresp_o     (bresp     ),
    .bvalid_o    (bvalid    ),
    .bready_i    (bready    ),
    .araddr_i    (araddr    ),
    .arvalid_i   (arvalid   ),
    .arready_o   (arready   ),
    .rdata_o     (rdata     ),
    .rresp_o     (rresp     ),
    .rvalid_o    (rvalid    ),
    .rready_i    (rready    ),
    .exit_code_o (exit_code ),
    .exit_valid_o(exit_valid),
    .char_o      (char_data ),
    .char_valid_o(char_valid),
    .char_count_o(char_count)
  );

  `include "tb_axil_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Count character pulses mid-cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1 && char_valid === 1'b1) begin
      char_pulses++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error test %s (%s): expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", cur_test, test_errs);
      n_fail++;
    end
  endtask

  // Strobe rule, one byte lane at a time
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    if (addr[HOST_SEL_BIT]) begin
      if (addr[3:0] == HOST_CHAR_OFS[3:0] && strb[0]) begin
        m_count = m_count + 16'd1;
      end else if (addr[3:0] == HOST_EXIT_OFS[3:0]) begin
        m_exit       = merge_bytes(m_exit, data, strb);
        m_exit_valid = 1'b1;
      end
    end else begin
      ref_mem[addr[2 +: IDX_W]] = merge_bytes(ref_mem[addr[2 +: IDX_W]], data, strb);
    end
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (addr[HOST_SEL_BIT]) begin
      if (addr[3:0] == HOST_CHAR_OFS[3:0]) begin
        return {16'h0000, m_count};
      end
      return (addr[3:0] == HOST_EXIT_OFS[3:0]) ? m_exit : 32'h0;
    end
    return ref_mem[addr[2 +: IDX_W]];
  endfunction

  task automatic add_entry(input string name, input bit wr, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb, input int hold);
    tbl_name[n_entries] = name;
    tbl_wr[n_entries]   = wr;
    tbl_addr[n_entries] = addr;
    tbl_data[n_entries] = data;
    tbl_strb[n_entries] = strb;
    tbl_hold[n_entries] = hold;
    if (wr) begin
      model_write(addr, data, strb);
      tbl_exp[n_entries] = '0;
    end else begin
      tbl_exp[n_entries] = model_read(addr);
    end
    tbl_count[n_entries]  = m_count;
    tbl_xvalid[n_entries] = m_exit_valid;
    tbl_xcode[n_entries]  = m_exit;
    n_entries++;
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] d;
    lfsr_state   = 32'h4049;
    m_count      = '0;
    m_exit       = '0;
    m_exit_valid = 1'b0;
    n_entries    = 0;
    // Full words at random word addresses, each read straight back
    for (int k = 0; k < 4; k++) begin
      a = take_bits(IDX_W) << 2;
      d = take_bits(32);
      add_entry($sformatf("rand_wr%0d", k), 1'b1, a, d, 4'hf, 0);
      add_entry($sformatf("rand_rd%0d", k), 1'b0, a, 32'h0, 4'h0, 0);
    end
    add_entry("part_full", 1'b1, 32'h0000_0040, 32'h1122_3344, 4'hf, 0);
    add_entry("part_strb", 1'b1, 32'h0000_0040, 32'hAABB_CCDD, 4'b0101, 0);
    add_entry("part_rd", 1'b0, 32'h0000_0040, 32'h0, 4'h0, 0);
    add_entry("char_wr", 1'b1, HOST_BASE + HOST_CHAR_OFS, 32'h0000_0041, 4'hf, 0);
    add_entry("char_rd", 1'b0, HOST_BASE + HOST_CHAR_OFS, 32'h0, 4'h0, 0);
    add_entry("exit_wr", 1'b1, HOST_BASE + HOST_EXIT_OFS, 32'hC0DE_002A, 4'hf, 0);
    add_entry("exit_rd", 1'b0, HOST_BASE + HOST_EXIT_OFS, 32'h0, 4'h0, 0);
    // Back-pressure on B and R
    add_entry("stall_wr", 1'b1, 32'h0000_0080, take_bits(32), 4'hf, 5);
    add_entry("stall_rd", 1'b0, 32'h0000_0080, 32'h0, 4'h0, 5);
  endtask

  initial begin
    logic [1:0]  resp;
    logic [31:0] got;
    int          pulses_before;
    logic        is_char;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    build_table();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    begin_test("reset_state");
    check_eq("bvalid", 32'h0, 32'(bvalid));
    check_eq("rvalid", 32'h0, 32'(rvalid));
    check_eq("exit_valid", 32'h0, 32'(exit_valid));
    check_eq("char_valid", 32'h0, 32'(char_valid));
    check_eq("char_count", 32'h0, 32'(char_count));
    check_eq("awready", 32'h1, 32'(awready));
    check_eq("wready", 32'h1, 32'(wready));
    check_eq("arready", 32'h1, 32'(arready));
    end_test();
    @(posedge clk);
    #1;

    for (int i = 0; i < n_entries; i++) begin
      begin_test(tbl_name[i]);
      pulses_before = char_pulses;
      if (tbl_wr[i]) begin
        axil_write(tbl_addr[i], tbl_data[i], tbl_strb[i], tbl_hold[i], resp);
        check_eq("bresp", 32'(RESP_OKAY), 32'(resp));
      end else begin
        axil_read(tbl_addr[i], tbl_hold[i], got, resp);
        check_eq("rresp", 32'(RESP_OKAY), 32'(resp));
        check_eq("rdata", tbl_exp[i], got);
      end
      is_char = tbl_wr[i] && (tbl_addr[i] == HOST_BASE + HOST_CHAR_OFS);
      check_eq("char pulses", is_char ? 32'h1 : 32'h0, 32'(char_pulses - pulses_before));
      if (is_char) begin
        check_eq("char", 32'(tbl_data[i][7:0]), 32'(char_data));
      end
      check_eq("char_count", 32'(tbl_count[i]), 32'(char_count));
      check_eq("exit_valid", 32'(tbl_xvalid[i]), 32'(exit_valid));
      check_eq("exit_code", tbl_xcode[i], exit_code);
      end_test();
    end

    $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_harness

`default_nettype wire

// ==== harness.f ====
+incdir+include
source/harness_pkg.sv
source/mem_req_if.sv
source/axil_to_mem.sv
source/mem_router.sv
source/tc_sram.sv
source/host_ctrl.sv
source/harness_top.sv
dv/tb_harness.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_harness
RTL_TOP    ?= harness_top
FILELIST   ?= harness.f
BUILD_DIR  ?= build
LOG        ?= $(BUILD_DIR)/sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, the exit status of the binary is not trusted
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
